/* logic/adc_acq_defs.svh */
`ifndef ADC_ACQ_DEFS_SVH
`define ADC_ACQ_DEFS_SVH

// flops in each enable and trigger synchronizer chain
`define ADC_ACQ_SYNC_STAGES 4

// data words per waveform, one count per fill type
`define ADC_ACQ_BURSTS_T1 2
`define ADC_ACQ_BURSTS_T2 4
`define ADC_ACQ_BURSTS_T3 8

// word FIFO ahead of the wishbone master, power of two
`define ADC_ACQ_FIFO_DEPTH 16

// tags in bits 127:112 of header and checksum words
`define ADC_ACQ_FILL_MARK 16'hF111
`define ADC_ACQ_WFM_MARK  16'hA0A0
`define ADC_ACQ_CSUM_MARK 16'hC5C5

`endif

/* logic/adc_acq_pkg.sv */
`default_nettype none

package adc_acq_pkg;

    // one adc sample
    typedef logic [11:0] sample_t;
    // two samples, each in the low 12 bits of a 16-bit lane
    typedef logic [31:0] sample_pair_t;
    // one stored word, four pairs or a header
    typedef logic [127:0] acq_word_t;
    // wishbone word address
    typedef logic [23:0] wb_addr_t;
    // the two enable bits
    typedef logic [1:0] fill_type_t;
    typedef logic [7:0] wfm_count_t;
    typedef logic [7:0] burst_count_t;
    typedef logic [15:0] fill_num_t;
    typedef logic [31:0] checksum_t;

    // acquisition sequence
    typedef enum logic [4:0] {
        IDLE, WATCH_FOR_TRIG, FILL_INIT1, FILL_INIT2,
        WAVEFORM_INIT1, WAVEFORM_INIT2, WAVEFORM_INIT3,
        RUN1, RUN2, RUN3, RUN4, WAVEFORM_TST,
        CHECKSUM1, CHECKSUM2, DDR3_WAIT, DONE
    } acq_state_t;

    // wishbone write master
    typedef enum logic {WR_IDLE, WR_CYCLE} wr_state_t;

endpackage

`default_nettype wire

/* logic/adc_acq_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface adc_acq_ctrl_if import adc_acq_pkg::*; ();

    // strobes from the state machine
    logic fill_init;
    logic wfm_init;
    logic sample_en;
    logic fill_hdr_sel;
    logic wfm_hdr_sel;
    logic dat_sel;
    logic csum_sel;
    logic word_valid;
    logic burst_en;
    logic wfm_en;
    logic fill_en;

    // counter status back to the state machine and packer
    logic burst_zero;
    logic last_waveform;
    fill_num_t fill_num;
    wfm_count_t wfm_idx;

    modport sm (
        output fill_init, wfm_init, sample_en, fill_hdr_sel, wfm_hdr_sel, dat_sel,
        output csum_sel, word_valid, burst_en, wfm_en, fill_en,
        input burst_zero, last_waveform
    );
    modport counters (
        input fill_init, wfm_init, burst_en, wfm_en, fill_en,
        output burst_zero, last_waveform, fill_num, wfm_idx
    );
    modport packer (
        input fill_init, wfm_init, sample_en, fill_hdr_sel, wfm_hdr_sel, dat_sel,
        input csum_sel, word_valid, fill_num, wfm_idx
    );

endinterface

`default_nettype wire

/* logic/adc_acq_sm.sv */
`timescale 1ns/1ps
`include "adc_acq_defs.svh"
`default_nettype none

module adc_acq_sm import adc_acq_pkg::*; (
    input  logic       clk,
    input  logic       adc_acq_full_reset,
    input  logic       acq_enable0,
    input  logic       acq_enable1,
    input  logic       acq_trig,
    input  logic       wr_idle,
    output fill_type_t fill_type,
    output logic       acq_enabled,
    output logic       acq_done,
    output logic       sm_idle,
    adc_acq_ctrl_if.sm ctrl
);

    localparam int SYNC = `ADC_ACQ_SYNC_STAGES;

    // synchronizer chains, raw input enters at bit 0
    logic [SYNC-1:0] en0_sync;
    logic [SYNC-1:0] en1_sync;
    logic [SYNC-1:0] trig_sync;
    // armed whenever either enable bit is set
    logic armed;
    logic trig;
    acq_state_t state;
    acq_state_t next_state;

    assign trig = trig_sync[SYNC-1];

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            en0_sync  <= '0;
            en1_sync  <= '0;
            trig_sync <= '0;
            armed     <= 1'b0;
            fill_type <= '0;
        end else begin
            en0_sync  <= {en0_sync[SYNC-2:0], acq_enable0};
            en1_sync  <= {en1_sync[SYNC-2:0], acq_enable1};
            trig_sync <= {trig_sync[SYNC-2:0], acq_trig};
            armed     <= en0_sync[SYNC-1] | en1_sync[SYNC-1];
            // fill type is the enable pair itself
            fill_type <= {en1_sync[SYNC-1], en0_sync[SYNC-1]};
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (armed)
                    next_state = WATCH_FOR_TRIG;
            end
            // wait armed for a trigger, drop back if disarmed
            WATCH_FOR_TRIG: begin
                if (!armed)
                    next_state = IDLE;
                else if (trig)
                    next_state = FILL_INIT1;
            end
            FILL_INIT1:     next_state = FILL_INIT2;
            FILL_INIT2:     next_state = WAVEFORM_INIT1;
            WAVEFORM_INIT1: next_state = WAVEFORM_INIT2;
            WAVEFORM_INIT2: next_state = WAVEFORM_INIT3;
            WAVEFORM_INIT3: next_state = RUN1;
            RUN1:           next_state = RUN2;
            RUN2:           next_state = RUN3;
            RUN3:           next_state = RUN4;
            // loop bursts until the burst counter runs out
            RUN4: begin
                next_state = ctrl.burst_zero ? WAVEFORM_TST : RUN1;
            end
            WAVEFORM_TST: begin
                next_state = ctrl.last_waveform ? CHECKSUM1 : WAVEFORM_INIT1;
            end
            CHECKSUM1:      next_state = CHECKSUM2;
            CHECKSUM2:      next_state = DDR3_WAIT;
            // writer must drain every word before done
            DDR3_WAIT: begin
                if (wr_idle)
                    next_state = DONE;
            end
            // hold until trigger or arming goes away, no retrigger
            DONE: begin
                if (!(armed && trig))
                    next_state = IDLE;
            end
            default:        next_state = IDLE;
        endcase
    end

    // outputs registered from the next state, valid on state entry
    always_ff @(posedge clk) begin
        ctrl.fill_init    <= 1'b0;
        ctrl.wfm_init     <= 1'b0;
        ctrl.sample_en    <= 1'b0;
        ctrl.fill_hdr_sel <= 1'b0;
        ctrl.wfm_hdr_sel  <= 1'b0;
        ctrl.dat_sel      <= 1'b0;
        ctrl.csum_sel     <= 1'b0;
        ctrl.word_valid   <= 1'b0;
        ctrl.burst_en     <= 1'b0;
        ctrl.wfm_en       <= 1'b0;
        ctrl.fill_en      <= 1'b0;
        acq_enabled       <= 1'b0;
        acq_done          <= 1'b0;
        sm_idle           <= 1'b0;
        if (adc_acq_full_reset) begin
            sm_idle <= 1'b1;
        end else begin
            acq_enabled <= !(next_state inside {IDLE, WATCH_FOR_TRIG});
            // data word leaves the cycle after RUN4
            ctrl.word_valid <= (state == RUN4);
            unique case (next_state)
                IDLE: sm_idle <= 1'b1;
                FILL_INIT1: begin
                    ctrl.fill_init    <= 1'b1;
                    ctrl.fill_hdr_sel <= 1'b1;
                end
                FILL_INIT2: ctrl.word_valid <= 1'b1;
                WAVEFORM_INIT1: begin
                    ctrl.wfm_init <= 1'b1;
                    // step the index only between waveforms
                    ctrl.wfm_en   <= (state == WAVEFORM_TST);
                end
                WAVEFORM_INIT2: ctrl.wfm_hdr_sel <= 1'b1;
                WAVEFORM_INIT3: ctrl.word_valid <= 1'b1;
                RUN1: begin
                    ctrl.sample_en <= 1'b1;
                    ctrl.burst_en  <= 1'b1;
                end
                RUN2, RUN3: ctrl.sample_en <= 1'b1;
                // last pair of the word goes straight into the mux
                RUN4: begin
                    ctrl.sample_en <= 1'b1;
                    ctrl.dat_sel   <= 1'b1;
                end
                CHECKSUM1: ctrl.csum_sel <= 1'b1;
                CHECKSUM2: begin
                    ctrl.word_valid <= 1'b1;
                    ctrl.fill_en    <= 1'b1;
                end
                DONE: acq_done <= 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/adc_acq_counters.sv */
`timescale 1ns/1ps
`include "adc_acq_defs.svh"
`default_nettype none

module adc_acq_counters import adc_acq_pkg::*; (
    input  logic             clk,
    input  logic             adc_acq_full_reset,
    input  fill_type_t       fill_type,
    input  wfm_count_t       num_waveforms,
    adc_acq_ctrl_if.counters ctrl
);

    // fill type held for the whole fill
    fill_type_t fill_type_q;
    burst_count_t burst_cnt;
    burst_count_t burst_load;

    // bursts per waveform for the latched type
    always_comb begin
        unique case (fill_type_q)
            2'd2:    burst_load = burst_count_t'(`ADC_ACQ_BURSTS_T2);
            2'd3:    burst_load = burst_count_t'(`ADC_ACQ_BURSTS_T3);
            default: burst_load = burst_count_t'(`ADC_ACQ_BURSTS_T1);
        endcase
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            fill_type_q   <= '0;
            burst_cnt     <= '0;
            ctrl.wfm_idx  <= '0;
            ctrl.fill_num <= '0;
        end else begin
            if (ctrl.fill_init)
                fill_type_q <= fill_type;
            // burst count loads per waveform, drops once per word
            if (ctrl.wfm_init)
                burst_cnt <= burst_load;
            else if (ctrl.burst_en && burst_cnt != '0)
                burst_cnt <= burst_cnt - 8'd1;
            // waveform index restarts each fill
            if (ctrl.fill_init)
                ctrl.wfm_idx <= '0;
            else if (ctrl.wfm_en)
                ctrl.wfm_idx <= ctrl.wfm_idx + 8'd1;
            // fills since reset, bumped as the checksum is sent
            if (ctrl.fill_en)
                ctrl.fill_num <= ctrl.fill_num + 16'd1;
        end
    end

    assign ctrl.burst_zero = (burst_cnt == '0);
    // a count of 0 wraps and means 256 waveforms
    assign ctrl.last_waveform = ((ctrl.wfm_idx + 8'd1) == num_waveforms);

endmodule

`default_nettype wire

/* logic/adc_acq_packer.sv */
`timescale 1ns/1ps
`include "adc_acq_defs.svh"
`default_nettype none

module adc_acq_packer import adc_acq_pkg::*; (
    input  logic           clk,
    input  logic           adc_acq_full_reset,
    input  sample_pair_t   adc_samples,
    input  logic           use_dummy,
    input  logic           dummy_dat_reset_mode,
    input  fill_type_t     fill_type,
    input  wfm_count_t     num_waveforms,
    adc_acq_ctrl_if.packer ctrl,
    output acq_word_t      acq_word,
    output logic           word_valid
);

    // dummy ramp, one step per sample
    sample_t ramp_q;
    sample_t ramp_next;
    sample_pair_t live_pair;
    sample_pair_t dummy_pair;
    sample_pair_t pair;
    // three earlier pairs of the word, oldest in the low bits
    logic [95:0] data_sr;
    checksum_t checksum;

    assign ramp_next = ramp_q + 12'd1;
    // keep only the 12 sample bits of each lane
    assign live_pair  = {4'h0, adc_samples[27:16], 4'h0, adc_samples[11:0]};
    // low lane carries the earlier sample
    assign dummy_pair = {4'h0, ramp_next, 4'h0, ramp_q};
    assign pair       = use_dummy ? dummy_pair : live_pair;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            ramp_q   <= '0;
            checksum <= '0;
        end else begin
            if (ctrl.wfm_init && dummy_dat_reset_mode)
                ramp_q <= '0;
            else if (ctrl.sample_en)
                ramp_q <= ramp_q + 12'd2;
            // checksum sums every data pair of the fill
            if (ctrl.fill_init)
                checksum <= '0;
            else if (ctrl.sample_en)
                checksum <= checksum + pair;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.sample_en)
            data_sr <= {pair, data_sr[95:32]};
    end

    // word register, loaded on a select and held until the next
    always_ff @(posedge clk) begin
        if (ctrl.fill_hdr_sel) begin
            acq_word <= {`ADC_ACQ_FILL_MARK, 6'd0, fill_type, ctrl.fill_num,
                         num_waveforms, 80'd0};
        end else if (ctrl.wfm_hdr_sel) begin
            acq_word <= {`ADC_ACQ_WFM_MARK, ctrl.fill_num, ctrl.wfm_idx, 88'd0};
        end else if (ctrl.dat_sel) begin
            // fourth pair joins the word in the same cycle
            acq_word <= {pair, data_sr};
        end else if (ctrl.csum_sel) begin
            acq_word <= {`ADC_ACQ_CSUM_MARK, 80'd0, checksum};
        end
    end

    // valid lines up one cycle after the word register
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset)
            word_valid <= 1'b0;
        else
            word_valid <= ctrl.word_valid;
    end

endmodule

`default_nettype wire

/* logic/adc_acq_wb_writer.sv */
`timescale 1ns/1ps
`include "adc_acq_defs.svh"
`default_nettype none

module adc_acq_wb_writer import adc_acq_pkg::*; (
    input  logic        clk,
    input  logic        adc_acq_full_reset,
    input  acq_word_t   acq_word,
    input  logic        word_valid,
    input  logic        wb_ack,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output wb_addr_t    wb_adr,
    output acq_word_t   wb_wdata,
    output logic [15:0] wb_sel,
    output logic        wr_idle,
    output logic        fifo_overflow
);

    localparam int DEPTH = `ADC_ACQ_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    acq_word_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic full;
    logic push;
    logic pop;
    wr_state_t state;

    assign full = (count == (PTR_W+1)'(DEPTH));
    // words arriving on a full FIFO are lost
    assign push = word_valid && !full;
    assign pop  = (state == WR_CYCLE) && wb_ack;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= acq_word;
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            state         <= WR_IDLE;
            wb_adr        <= '0;
            fifo_overflow <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
            // sticky until reset
            if (word_valid && full)
                fifo_overflow <= 1'b1;
            // idle always lasts a cycle between words
            unique case (state)
                WR_IDLE: begin
                    if (count != '0)
                        state <= WR_CYCLE;
                end
                WR_CYCLE: begin
                    if (wb_ack) begin
                        state  <= WR_IDLE;
                        wb_adr <= wb_adr + 24'd1;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // cycle signals follow the state, data is the FIFO head
    assign wb_cyc   = (state == WR_CYCLE);
    assign wb_stb   = (state == WR_CYCLE);
    assign wb_we    = (state == WR_CYCLE);
    assign wb_wdata = mem[rd_ptr];
    assign wb_sel   = '1;
    // an incoming word still counts as pending work
    assign wr_idle  = (count == '0) && (state == WR_IDLE) && !word_valid;

endmodule

`default_nettype wire

/* logic/adc_acq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_acq_top import adc_acq_pkg::*; (
    input  logic         clk,
    input  logic         adc_acq_full_reset,
    input  logic         acq_enable0,
    input  logic         acq_enable1,
    input  logic         acq_trig,
    input  sample_pair_t adc_samples,
    input  logic         use_dummy,
    input  logic         dummy_dat_reset_mode,
    input  wfm_count_t   num_waveforms,
    input  logic         wb_ack,
    output logic         wb_cyc,
    output logic         wb_stb,
    output logic         wb_we,
    output wb_addr_t     wb_adr,
    output acq_word_t    wb_wdata,
    output logic [15:0]  wb_sel,
    output logic         acq_enabled,
    output logic         acq_done,
    output logic         sm_idle,
    output logic         fifo_overflow
);

    fill_type_t fill_type;
    acq_word_t acq_word;
    logic word_valid;
    logic wr_idle;

    // strobes and counter status between sm, counters and packer
    adc_acq_ctrl_if ctrl ();

    adc_acq_sm sm_inst (
        .clk, .adc_acq_full_reset, .acq_enable0, .acq_enable1, .acq_trig,
        .wr_idle, .fill_type, .acq_enabled, .acq_done, .sm_idle,
        .ctrl(ctrl.sm)
    );

    adc_acq_counters counters_inst (
        .clk, .adc_acq_full_reset, .fill_type, .num_waveforms,
        .ctrl(ctrl.counters)
    );

    adc_acq_packer packer_inst (
        .clk, .adc_acq_full_reset, .adc_samples, .use_dummy, .dummy_dat_reset_mode,
        .fill_type, .num_waveforms, .ctrl(ctrl.packer), .acq_word, .word_valid
    );

    // FIFO and wishbone master toward memory
    adc_acq_wb_writer wb_writer_inst (
        .clk, .adc_acq_full_reset, .acq_word, .word_valid, .wb_ack,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_sel,
        .wr_idle, .fifo_overflow
    );

endmodule

`default_nettype wire

/* testbench/adc_acq_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_acq_asserts import adc_acq_pkg::*; (
    input logic      clk,
    input logic      adc_acq_full_reset,
    input logic      wb_cyc,
    input logic      wb_stb,
    input logic      wb_ack,
    input wb_addr_t  wb_adr,
    input acq_word_t wb_wdata,
    input logic      acq_done,
    input logic      sm_idle
);

    // number of assertion failures so far
    int fail_count = 0;

    // strobe only inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        wb_stb |-> wb_cyc)
    else begin
        fail_count++;
        $error("wb_stb high without wb_cyc");
    end

    // an unacknowledged write keeps its strobe, address and data
    stb_held_stable: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_wdata)))
    else begin
        fail_count++;
        $error("write changed or dropped before wb_ack");
    end

    // done and idle come from different states
    done_not_idle: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        !(acq_done && sm_idle))
    else begin
        fail_count++;
        $error("acq_done and sm_idle high together");
    end

endmodule

bind adc_acq_top adc_acq_asserts asserts_inst (.*);

`default_nettype wire

/* testbench/adc_acq_tb.sv */
`timescale 1ns/1ps
`include "adc_acq_defs.svh"
`default_nettype none

module adc_acq_tb import adc_acq_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 30;
    localparam int DRIVE_DELAY  = 2;

    logic         clk;
    logic         adc_acq_full_reset;
    logic         acq_enable0;
    logic         acq_enable1;
    logic         acq_trig;
    sample_pair_t adc_samples;
    logic         use_dummy;
    logic         dummy_dat_reset_mode;
    wfm_count_t   num_waveforms;
    logic         wb_ack;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    wb_addr_t     wb_adr;
    acq_word_t    wb_wdata;
    logic [15:0]  wb_sel;
    logic         acq_enabled;
    logic         acq_done;
    logic         sm_idle;
    logic         fifo_overflow;

    // case table with one entry per line of the cases file
    string case_name[$];
    int    case_ft[$];
    int    case_nw[$];
    int    case_dummy[$];
    int    case_mode[$];
    int    case_ack[$];
    int    case_ovf[$];
    int    errors = 0;
    int    checks = 0;
    int    seed = 62663;
    int    ack_delay = 0;
    int    ack_wait = 0;
    // watchdog cycles that grow with every case read
    int    budget = 5000;
    logic  cases_loaded = 1'b0;
    // writes seen by the wishbone responder
    wb_addr_t  got_adr[$];
    acq_word_t got_word[$];
    // expected fill with the live data words flagged
    acq_word_t exp_word[$];
    logic      exp_live[$];
    // model state that carries across fills
    sample_t   model_ramp;
    fill_num_t model_fill;
    wb_addr_t  model_addr;

    adc_acq_top adc_acq_top_inst (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // move to the drive point just after the next rising edge
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_word(input string name, input acq_word_t exp, input acq_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input wb_addr_t exp, input wb_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_sel(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    // data words per waveform for a fill type
    function automatic int bursts_for(input fill_type_t ft);
        case (ft)
            2'd2:    return `ADC_ACQ_BURSTS_T2;
            2'd3:    return `ADC_ACQ_BURSTS_T3;
            default: return `ADC_ACQ_BURSTS_T1;
        endcase
    endfunction

    // expected word list of one fill where the ramp also advances in live fills
    task automatic build_expected(input fill_type_t ft, input wfm_count_t nw,
                                  input logic mode, input logic live);
        int wf;
        int b;
        int p;
        sample_t hi;
        acq_word_t w;
        checksum_t sum;
        sum = '0;
        w = '0;
        exp_word.delete();
        exp_live.delete();
        exp_word.push_back({`ADC_ACQ_FILL_MARK, 6'd0, ft, model_fill, nw, 80'd0});
        exp_live.push_back(1'b0);
        for (wf = 0; wf < nw; wf++) begin
            if (mode)
                model_ramp = '0;
            exp_word.push_back({`ADC_ACQ_WFM_MARK, model_fill, wfm_count_t'(wf), 88'd0});
            exp_live.push_back(1'b0);
            for (b = 0; b < bursts_for(ft); b++) begin
                // pair p holds samples 2p and 2p+1 with the earlier one in the low lane
                for (p = 0; p < 4; p++) begin
                    hi = model_ramp + 12'd1;
                    w[32*p +: 32] = {4'h0, hi, 4'h0, model_ramp};
                    sum = sum + {4'h0, hi, 4'h0, model_ramp};
                    model_ramp = model_ramp + 12'd2;
                end
                exp_word.push_back(w);
                exp_live.push_back(live);
            end
        end
        exp_word.push_back({`ADC_ACQ_CSUM_MARK, 80'd0, sum});
        exp_live.push_back(1'b0);
        model_fill++;
    endtask

    task automatic read_cases();
        int fd;
        int n;
        string line;
        string nm;
        int ft;
        int nw;
        int dm;
        int rm;
        int ad;
        int ov;
        fd = $fopen("testbench/adc_acq_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: cannot open testbench/adc_acq_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip blank and comment lines
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%s %d %d %d %d %d %d", nm, ft, nw, dm, rm, ad, ov);
            if (n != 7) begin
                errors++;
                $display("ERROR: malformed line in cases file: %s", line);
                continue;
            end
            case_name.push_back(nm);
            case_ft.push_back(ft);
            case_nw.push_back(nw);
            case_dummy.push_back(dm);
            case_mode.push_back(rm);
            case_ack.push_back(ad);
            case_ovf.push_back(ov);
            budget += (2 + nw * (1 + bursts_for(fill_type_t'(ft)))) * (ad + 4) * 40;
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        adc_acq_full_reset = 1'b1;
        repeat (RESET_CYCLES)
            step();
        adc_acq_full_reset = 1'b0;
        model_ramp = '0;
        model_fill = '0;
        model_addr = '0;
    endtask

    task automatic run_case(input int idx);
        string name;
        fill_type_t ft;
        wfm_count_t nw;
        int held;
        int i;
        int p;
        checksum_t live_sum;
        acq_word_t pad_mask;
        name = case_name[idx];
        ft = fill_type_t'(case_ft[idx]);
        nw = wfm_count_t'(case_nw[idx]);
        // top four bits of every 16-bit lane
        pad_mask = {8{16'hF000}};
        $display("case %s: type %0d, %0d waveforms, dummy %0d, mode %0d, ack delay %0d",
                 name, ft, nw, case_dummy[idx], case_mode[idx], case_ack[idx]);
        // disarm so the new fill type settles through the synchronizers
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        acq_trig = 1'b0;
        while (!sm_idle)
            step();
        repeat (8)
            step();
        use_dummy = (case_dummy[idx] != 0);
        dummy_dat_reset_mode = (case_mode[idx] != 0);
        num_waveforms = nw;
        ack_delay = case_ack[idx];
        acq_enable0 = ft[0];
        acq_enable1 = ft[1];
        while (sm_idle)
            step();
        build_expected(ft, nw, dummy_dat_reset_mode, !use_dummy);
        got_adr.delete();
        got_word.delete();
        acq_trig = 1'b1;
        while (!acq_done)
            step();
        // every word acknowledged by the time done shows
        if (case_ovf[idx] == 0)
            check_count($sformatf("%s acked before done", name), exp_word.size(),
                        got_word.size());
        check_flag($sformatf("%s enabled in done", name), 1'b1, acq_enabled);
        held = got_word.size();
        // trigger still high so done holds and no second fill starts
        repeat (HOLD_CYCLES) begin
            step();
            check_flag($sformatf("%s done held", name), 1'b1, acq_done);
            check_flag($sformatf("%s no cycle in done", name), 1'b0, wb_cyc);
        end
        acq_trig = 1'b0;
        while (acq_done)
            step();
        repeat (HOLD_CYCLES) begin
            step();
            check_flag($sformatf("%s no fill without trigger", name), 1'b0, wb_cyc);
        end
        check_count($sformatf("%s words after done", name), held, got_word.size());
        if (case_ovf[idx] != 0) begin
            check_flag($sformatf("%s overflow set", name), 1'b1, fifo_overflow);
            // lost words break the model and need a fresh reset
            apply_reset();
            check_flag($sformatf("%s overflow cleared", name), 1'b0, fifo_overflow);
        end else begin
            check_flag($sformatf("%s overflow low", name), 1'b0, fifo_overflow);
            live_sum = '0;
            for (i = 0; i < got_word.size() && i < exp_word.size(); i++) begin
                check_addr($sformatf("%s address %0d", name, i),
                           model_addr + wb_addr_t'(i), got_adr[i]);
                if (exp_live[i]) begin
                    check_word($sformatf("%s live padding %0d", name, i), '0,
                               got_word[i] & pad_mask);
                    for (p = 0; p < 4; p++)
                        live_sum = live_sum + got_word[i][32*p +: 32];
                end else if (!use_dummy && i == exp_word.size() - 1) begin
                    // live checksum from the pairs actually written
                    check_word($sformatf("%s live checksum", name),
                               {`ADC_ACQ_CSUM_MARK, 80'd0, live_sum}, got_word[i]);
                end else begin
                    check_word($sformatf("%s word %0d", name, i), exp_word[i], got_word[i]);
                end
            end
            model_addr = model_addr + wb_addr_t'(got_word.size());
        end
    endtask

    // fresh live samples every cycle
    always @(posedge clk) begin
        #DRIVE_DELAY;
        adc_samples = $random(seed);
    end

    // wishbone slave that acks after the case delay for one cycle
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (ack_wait >= ack_delay) begin
                check_flag("write enable with strobe", 1'b1, wb_we);
                // every write covers all sixteen byte lanes
                check_sel("byte lanes with strobe", 16'hFFFF, wb_sel);
                got_adr.push_back(wb_adr);
                got_word.push_back(wb_wdata);
                wb_ack = 1'b1;
                ack_wait = 0;
            end else begin
                ack_wait++;
            end
        end
    end

    // watchdog sized from the cases read
    initial begin
        wait (cases_loaded);
        repeat (budget)
            @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, a fill never finished", budget);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int n;
        int assert_fails;
        adc_acq_full_reset = 1'b1;
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        acq_trig = 1'b0;
        adc_samples = '0;
        use_dummy = 1'b1;
        dummy_dat_reset_mode = 1'b0;
        num_waveforms = 8'd1;
        wb_ack = 1'b0;
        read_cases();
        cases_loaded = 1'b1;
        apply_reset();
        // disarmed after reset so nothing moves
        repeat (40) begin
            step();
            check_flag("reset no cycle", 1'b0, wb_cyc);
            check_flag("reset idle", 1'b1, sm_idle);
            check_flag("reset not done", 1'b0, acq_done);
            check_flag("reset not enabled", 1'b0, acq_enabled);
        end
        check_flag("reset no overflow", 1'b0, fifo_overflow);
        check_addr("reset address", '0, wb_adr);
        for (n = 0; n < case_name.size(); n++)
            run_case(n);
        repeat (4)
            step();
        assert_fails = adc_acq_top_inst.asserts_inst.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/adc_acq_cases.txt */
# name fill_type num_waveforms use_dummy dummy_reset_mode ack_delay expect_overflow
# fill_type 1..3 sets the two enables, ack_delay in clock cycles
t1_dummy_restart 1 2 1 1 0 0
t2_dummy_restart 2 3 1 1 1 0
t3_dummy_restart 3 2 1 1 2 0
t1_dummy_cont 1 3 1 0 0 0
t2_dummy_cont 2 2 1 0 2 0
t2_live 2 3 0 0 1 0
t3_live 3 1 0 1 0 0
t1_dummy_after_live 1 2 1 0 1 0
t3_single_wfm 3 1 1 0 2 0
t3_slow_ack_overflow 3 4 1 1 20 1

/* flist.f */
+incdir+logic
logic/adc_acq_pkg.sv
logic/adc_acq_ctrl_if.sv
logic/adc_acq_sm.sv
logic/adc_acq_counters.sv
logic/adc_acq_packer.sv
logic/adc_acq_wb_writer.sv
logic/adc_acq_top.sv
testbench/adc_acq_asserts.sv
testbench/adc_acq_tb.sv

/* Bender.yml */
package:
  name: adc_acq

sources:
  - include_dirs:
      - logic
    files:
      - logic/adc_acq_pkg.sv
      - logic/adc_acq_ctrl_if.sv
      - logic/adc_acq_sm.sv
      - logic/adc_acq_counters.sv
      - logic/adc_acq_packer.sv
      - logic/adc_acq_wb_writer.sv
      - logic/adc_acq_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/adc_acq_asserts.sv
      - testbench/adc_acq_tb.sv
